/* files.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -j 0 --top-module tb_rv_core -f files.f -o tb_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    // cycles per program: 6 reset cycles plus length + 1 sampled cycles
    localparam int run_cycles = 15 + 3 * 51 + 11 + 18 * 12 + 9 + 11 + 41;
    localparam word_t nop_word = 32'h0000_0013;  // addi x0, x0, 0

    // funct3 per ALU op: add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] sel_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                           3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic      clk;
    logic      reset;
    logic      fill_req;
    word_t     inst_addr;
    word_t     inst;
    word_t     dmem_rdata;
    dmem_req_t dmem_req;
    word_t     imem_off;
    word_t     imem [256];
    word_t     dmem [256];
    word_t     trace [64];  // inst_addr seen in each cycle
    int        prog_len;
    int        errors;

    rv_core i_dut (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst       (inst),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // instruction memory, word offset from reset_pc
    assign imem_off   = inst_addr - reset_pc;
    assign inst       = (imem_off < 32'd1024) ? imem[imem_off[9:2]] : nop_word;
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    function automatic word_t fill_word(input int idx);
        logic [7:0] i8;
        i8 = idx[7:0];
        return {i8, ~i8, i8 ^ 8'h5a, i8 + 8'h33};
    endfunction

    always @(posedge clk) begin
        if (fill_req) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_req.we) begin
            for (int l = 0; l < 4; l++) begin
                if (dmem_req.strb[l]) begin
                    dmem[dmem_req.addr[9:2]][8*l +: 8] <= dmem_req.wdata[8*l +: 8];
                end
            end
        end
    end

    function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // RV32I integer rules, shift amount is the low 5 bits of b
    function automatic word_t alu_model(input int sel, input word_t a, input word_t b);
        case (sel)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: return (a < b) ? 32'd1 : 32'd0;
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return word_t'($signed(a) >>> b[4:0]);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t want, input word_t got);
        if (got !== want) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, want, got);
        end
    endtask

    task automatic clear_program;
        for (int i = 0; i < 256; i++) begin
            imem[i] = nop_word;
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // lui + addi, upper part rounded for the signed low half
    task automatic load_const(input logic [4:0] rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        emit(enc_u(hi[31:12], rd, op_lui));
        emit(enc_i(v[11:0], rd, 3'd0, rd, op_imm));
    endtask

    // 5 cycles of reset, data memory preset on the first one
    task automatic reset_core;
        @(posedge clk);
        reset    <= 1'b1;
        fill_req <= 1'b1;
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            check_word("dmem_req.we", 32'd0, {31'd0, dmem_req.we});
            @(posedge clk);
            fill_req <= 1'b0;
        end
        reset <= 1'b0;
    endtask

    task automatic run_program(input int n);
        for (int k = 0; k <= n; k++) begin
            @(negedge clk);
            trace[k] = inst_addr;
        end
    endtask

    task automatic test_reset_fetch;
        clear_program();
        emit(enc_s(12'd0, 5'd0, 5'd0, 3'b010));  // a store sits at reset_pc during reset
        reset_core();
        run_program(8);
        for (int k = 0; k <= 8; k++) begin
            check_word("inst_addr", reset_pc + 32'(4 * k), trace[k]);
        end
    endtask

    task automatic test_alu;
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        logic [6:0]  f7;
        word_t       want [20];
        int          slot;
        for (int round = 0; round < 3; round++) begin
            a = $urandom;
            b = (round == 2) ? a : $urandom;  // last round compares equal operands
            clear_program();
            load_const(5'd1, a);
            load_const(5'd2, b);
            slot = 0;
            for (int sel = 0; sel < 10; sel++) begin
                f7 = (sel == 1 || sel == 7) ? 7'h20 : 7'h00;
                emit(enc_r(f7, 5'd2, 5'd1, sel_f3[sel], 5'd3));
                emit(enc_s(12'(4 * slot), 5'd3, 5'd0, 3'b010));
                want[slot] = alu_model(sel, a, b);
                slot++;
            end
            for (int sel = 0; sel < 10; sel++) begin
                if (sel != 1) begin
                    imm = 12'($urandom);
                    if (sel == 2 || sel == 6 || sel == 7) begin
                        f7  = (sel == 7) ? 7'h20 : 7'h00;
                        imm = {f7, imm[4:0]};
                    end
                    emit(enc_i(imm, 5'd1, sel_f3[sel], 5'd4, op_imm));
                    emit(enc_s(12'(4 * slot), 5'd4, 5'd0, 3'b010));
                    want[slot] = alu_model(sel, a, {{20{imm[11]}}, imm});
                    slot++;
                end
            end
            emit(enc_i(12'h123, 5'd1, 3'd0, 5'd0, op_imm));  // write to x0 is dropped
            emit(enc_s(12'(4 * slot), 5'd0, 5'd0, 3'b010));
            want[slot] = '0;
            slot++;
            reset_core();
            run_program(prog_len);
            for (int k = 0; k < slot; k++) begin
                check_word($sformatf("dmem[%0d]", k), want[k], dmem[k]);
            end
        end
    endtask

    task automatic test_lui_auipc;
        logic [19:0] u1;
        logic [19:0] u2;
        u1 = 20'($urandom);
        u2 = 20'($urandom);
        clear_program();
        emit(enc_u(u1, 5'd5, op_lui));
        emit(enc_s(12'd0, 5'd5, 5'd0, 3'b010));
        emit(enc_u(u2, 5'd6, op_auipc));  // at reset_pc + 8
        emit(enc_s(12'd4, 5'd6, 5'd0, 3'b010));
        reset_core();
        run_program(prog_len);
        check_word("dmem[0]", {u1, 12'b0}, dmem[0]);
        check_word("dmem[1]", reset_pc + 32'd8 + {u2, 12'b0}, dmem[1]);
    endtask

    task automatic test_branches;
        word_t r1;
        word_t r2;
        word_t a;
        word_t b;
        word_t want;
        int    off;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                r1  = $urandom | 32'h8000_0000;  // negative
                r2  = $urandom & 32'h7fff_ffff;  // positive
                a   = (p == 1) ? r1 : r2;
                b   = (p == 2) ? r1 : r2;
                off = int'($urandom % 19);
                off = off * 4 - 16;
                if (off >= 4) begin
                    off = off + 4;  // skip the fall-through address
                end
                clear_program();
                load_const(5'd1, a);
                load_const(5'd2, b);
                emit(enc_b(13'(off), 5'd2, 5'd1, br_f3[c]));  // branch at index 4
                reset_core();
                run_program(5);
                if (branch_model(br_f3[c], a, b)) begin
                    want = reset_pc + 32'd16 + word_t'(off);
                end else begin
                    want = reset_pc + 32'd20;
                end
                check_word("inst_addr", want, trace[5]);
            end
        end
    endtask

    task automatic test_jumps;
        int t;
        t = 2 + int'($urandom % 20);
        clear_program();
        emit(enc_j(21'(4 * t), 5'd1));
        imem[t] = enc_s(12'd0, 5'd1, 5'd0, 3'b010);
        reset_core();
        run_program(2);
        check_word("inst_addr", reset_pc + 32'(4 * t), trace[1]);
        check_word("dmem[0]", reset_pc + 32'd4, dmem[0]);

        t = 4 + int'($urandom % 20);
        clear_program();
        load_const(5'd2, reset_pc + 32'(4 * t + 13));  // odd base, sum has bit 0 set
        emit(enc_i(12'hff4, 5'd2, 3'd0, 5'd3, op_jalr));
        imem[t] = enc_s(12'd4, 5'd3, 5'd0, 3'b010);
        reset_core();
        run_program(4);
        check_word("inst_addr", reset_pc + 32'(4 * t), trace[3]);
        check_word("dmem[1]", reset_pc + 32'd12, dmem[1]);
    endtask

    task automatic test_load_store;
        word_t      v;
        word_t      src;
        word_t      want;
        logic [7:0]  b8;
        logic [15:0] h16;
        v = $urandom;
        clear_program();
        load_const(5'd1, v);
        for (int off = 0; off < 4; off++) begin
            emit(enc_s(12'(4 * (8 + off) + off), 5'd1, 5'd0, 3'b000));  // sb
        end
        for (int h = 0; h < 2; h++) begin
            emit(enc_s(12'(4 * (12 + h) + 2 * h), 5'd1, 5'd0, 3'b001));  // sh
        end
        for (int off = 0; off < 4; off++) begin
            emit(enc_i(12'(80 + off), 5'd0, 3'b000, 5'd5, op_load));  // lb
            emit(enc_s(12'(4 * (32 + off)), 5'd5, 5'd0, 3'b010));
            emit(enc_i(12'(80 + off), 5'd0, 3'b100, 5'd6, op_load));  // lbu
            emit(enc_s(12'(4 * (36 + off)), 5'd6, 5'd0, 3'b010));
        end
        for (int h = 0; h < 2; h++) begin
            emit(enc_i(12'(80 + 2 * h), 5'd0, 3'b001, 5'd5, op_load));  // lh
            emit(enc_s(12'(4 * (40 + h)), 5'd5, 5'd0, 3'b010));
            emit(enc_i(12'(80 + 2 * h), 5'd0, 3'b101, 5'd6, op_load));  // lhu
            emit(enc_s(12'(4 * (42 + h)), 5'd6, 5'd0, 3'b010));
        end
        emit(enc_i(12'd80, 5'd0, 3'b010, 5'd7, op_load));
        emit(enc_s(12'd176, 5'd7, 5'd0, 3'b010));
        reset_core();
        run_program(prog_len);

        src = fill_word(20);
        for (int off = 0; off < 4; off++) begin
            want = fill_word(8 + off);
            want[8*off +: 8] = v[7:0];
            check_word($sformatf("dmem[%0d]", 8 + off), want, dmem[8 + off]);
            b8 = src[8*off +: 8];
            check_word($sformatf("dmem[%0d]", 32 + off), {{24{b8[7]}}, b8}, dmem[32 + off]);
            check_word($sformatf("dmem[%0d]", 36 + off), {24'b0, b8}, dmem[36 + off]);
        end
        for (int h = 0; h < 2; h++) begin
            want = fill_word(12 + h);
            want[16*h +: 16] = v[15:0];
            check_word($sformatf("dmem[%0d]", 12 + h), want, dmem[12 + h]);
            h16 = src[16*h +: 16];
            check_word($sformatf("dmem[%0d]", 40 + h), {{16{h16[15]}}, h16}, dmem[40 + h]);
            check_word($sformatf("dmem[%0d]", 42 + h), {16'b0, h16}, dmem[42 + h]);
        end
        check_word("dmem[44]", src, dmem[44]);
    endtask

    initial begin
        reset    = 1'b1;
        fill_req = 1'b0;
        errors   = 0;
        prog_len = 0;
        void'($urandom(32'h5a98_1866));
        test_reset_fetch();
        test_alu();
        test_lui_auipc();
        test_branches();
        test_jumps();
        test_load_store();
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // all programs plus half again
    initial begin
        #(run_cycles * 60);
        $display("timeout: the run did not finish within %0d ns", run_cycles * 60);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     inst_addr,
    input  word_t     inst,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    word_t                 pc;
    word_t                 pc_plus4;
    logic                  jump_en;
    word_t                 jump_target;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    ctrl_t                 ctrl;
    word_t                 rs1_data;
    word_t                 rs2_data;
    word_t                 alu_result;
    word_t                 load_data;
    word_t                 wb_data;
    dmem_req_t             lsu_req;

    assign inst_addr = pc;

    rv_fetch i_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    rv_decode i_decode (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .ctrl (ctrl)
    );

    rv_regfile i_regfile (
        .clk    (clk),
        .we     (ctrl.reg_we & ~reset),  // no writeback while in reset
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_execute i_execute (
        .ctrl        (ctrl),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    rv_lsu i_lsu (
        .ctrl       (ctrl),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (lsu_req),
        .load_data  (load_data)
    );

    always_comb begin
        dmem_req    = lsu_req;
        dmem_req.we = lsu_req.we & ~reset;  // store blocked during reset
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_link: wb_data = pc_plus4;
            wb_load: wb_data = load_data;
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
    import rv_pkg::*;
(
    input  ctrl_t     ctrl,
    input  word_t     addr,
    input  word_t     store_data,
    input  word_t     dmem_rdata,
    output dmem_req_t dmem_req,
    output word_t     load_data
);

    logic [1:0] byte_off;
    word_t      rdata_shifted;
    word_t      load_ext;

    assign byte_off = addr[1:0];

    // replicate the value on every lane, strobes pick the live ones
    always_comb begin
        dmem_req.addr = addr;
        dmem_req.we   = ctrl.mem_write;
        case (ctrl.funct3[1:0])
            2'b00: begin
                dmem_req.wdata = {4{store_data[7:0]}};
                dmem_req.strb  = 4'b0001 << byte_off;
            end
            2'b01: begin
                dmem_req.wdata = {2{store_data[15:0]}};
                dmem_req.strb  = 4'b0011 << byte_off;
            end
            default: begin
                dmem_req.wdata = store_data;
                dmem_req.strb  = 4'b1111;
            end
        endcase
        if (!ctrl.mem_write) begin
            dmem_req.strb = 4'b0000;
        end
    end

    assign rdata_shifted = dmem_rdata >> {byte_off, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (ctrl.funct3)
            3'b000:  load_ext = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};    // lb
            3'b001:  load_ext = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};  // lh
            3'b100:  load_ext = {24'b0, rdata_shifted[7:0]};                     // lbu
            3'b101:  load_ext = {16'b0, rdata_shifted[15:0]};                    // lhu
            default: load_ext = dmem_rdata;                                      // lw
        endcase
    end

    assign load_data = ctrl.mem_read ? load_ext : '0;

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t alu_result,
    output logic  jump_en,
    output word_t jump_target
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       taken;

    always_comb begin
        case (ctrl.src_a)
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b  = ctrl.src_b_imm ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0];  // only low 5 bits count

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = word_t'($signed(op_a) >>> shamt);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // branch compare works on the raw register values
    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) <  $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data <  rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign jump_en = ctrl.is_jal | ctrl.is_jalr | (ctrl.is_branch & taken);

    // jalr target comes from the ALU sum, bit 0 cleared
    assign jump_target = ctrl.is_jalr ? {alu_result[xlen-1:1], 1'b0} : pc + ctrl.imm;

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  word_t                 wdata,
    output word_t                 rdata1,
    output word_t                 rdata2
);

    word_t regs [1 << reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  inst_u                 inst,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output ctrl_t                 ctrl
);

    logic [6:0] opcode;
    inst_fmt_t  fmt;
    word_t      imm;

    // funct3/funct7 pick the ALU op; sub only exists for register form
    function automatic alu_op_t alu_decode(input logic [2:0] funct3,
                                           input logic       funct7_5,
                                           input logic       is_reg);
        alu_op_t op;
        case (funct3)
            3'b000:  op = (is_reg && funct7_5) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = funct7_5 ? alu_sra : alu_srl;  // imm[10] for shift-imm
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = inst.r.opcode;
    assign rs1    = inst.r.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;

    always_comb begin
        case (opcode)
            op_reg:                    fmt = fmt_r;
            op_imm, op_load, op_jalr:  fmt = fmt_i;
            op_store:                  fmt = fmt_s;
            op_branch:                 fmt = fmt_b;
            op_lui, op_auipc:          fmt = fmt_u;
            op_jal:                    fmt = fmt_j;
            default:                   fmt = fmt_n;
        endcase
    end

    always_comb begin
        case (fmt)
            fmt_i: imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            fmt_s: imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            fmt_b: imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                          inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            fmt_u: imm = {inst.u.imm_31_12, 12'b0};
            fmt_j: imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                          inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default: imm = '0;  // r type and unknown
        endcase
    end

    always_comb begin
        ctrl           = '0;  // unknown opcode falls through as a no-op
        ctrl.alu_op    = alu_add;
        ctrl.src_a     = src_a_reg;
        ctrl.wb_sel    = wb_alu;
        ctrl.funct3    = inst.r.funct3;
        ctrl.imm       = imm;
        case (opcode)
            op_lui: begin
                ctrl.src_a     = src_a_zero;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_we    = 1'b1;
            end
            op_auipc: begin
                ctrl.src_a     = src_a_pc;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_we    = 1'b1;
            end
            op_jal: begin
                ctrl.is_jal = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = wb_link;
            end
            op_jalr: begin
                ctrl.is_jalr   = 1'b1;
                ctrl.src_b_imm = 1'b1;  // rs1 + imm through the ALU
                ctrl.reg_we    = 1'b1;
                ctrl.wb_sel    = wb_link;
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
            end
            op_load: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_we    = 1'b1;
                ctrl.wb_sel    = wb_load;
            end
            op_store: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b0);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_we    = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b1);
                ctrl.reg_we = 1'b1;
            end
            default: begin
                ctrl.reg_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t pc_plus4
);

    word_t next_pc;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = jump_en ? jump_target : pc_plus4;  // taken jump or branch wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef logic [xlen-1:0] word_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_n  // no immediate
    } inst_fmt_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        src_a_reg,
        src_a_pc,
        src_a_zero  // lui
    } src_a_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_link,  // pc+4
        wb_load
    } wb_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        src_a_t     src_a;
        logic       src_b_imm;
        logic       reg_we;
        wb_sel_t    wb_sel;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;
        word_t      imm;
    } ctrl_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] strb;  // byte lanes
        logic       we;
    } dmem_req_t;

endpackage

`default_nettype wire
